// File: flist.f
+incdir+verilog
verilog/mmu_pkg.sv
verilog/page_map.sv
verilog/page_status.sv
verilog/access_ctrl.sv
verilog/mmu_top.sv
tests/mmu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the paging unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module mmu_tb -o mmu_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/mmu_sim > sim.log 2>&1 || { echo "Simulation run failed, see sim.log"; exit 1; }

grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "No pass message in sim.log"; exit 1; }
echo "Simulation passed"

// File: tests/mmu_tb.sv
// Testbench for mmu_top with clock, reset, stimulus, reference model, checks and timeout
`timescale 1ns/1ps
`default_nettype none

`include "mmu_macros.svh"

module mmu_tb;

    import mmu_pkg::*;

    localparam int NUM_REQ   = 64;                      // Requests over all tests
    localparam int LIMIT     = 1200 + 100 * NUM_REQ;    // Cycle budget
    localparam int ACK_DELAY = 3;                       // Falling edges from i_req to ack

    logic clk = 1'b0;
    logic reset;
    logic i_map_we, i_no_paging, i_besm6, i_req;
    logic [`MMU_PAGE_BITS-1:0]  i_map_vpage, i_map_ppage, i_stat_page;
    arb_op_t                    i_opc;
    logic [`MMU_VADDR_BITS-1:0] i_vaddr, o_physad;
    logic i_stat_we, i_stat_used, i_stat_dirty, i_stat_reprio, i_fill_start;
    logic o_ack, o_used, o_dirty, o_reprio, o_fill_busy;

    // Reference state
    logic [`MMU_PAGE_BITS-1:0]  map_sh   [`MMU_NUM_PAGES];
    logic                       used_sh  [`MMU_NUM_PAGES];
    logic                       dirty_sh [`MMU_NUM_PAGES];
    logic                       reprio_sh[`MMU_NUM_PAGES];
    logic [`MMU_VADDR_BITS-1:0] exp_physad;
    logic [31:0] rnd;
    integer seed = 28;
    int errors = 0, checks = 0, requests = 0, cycles = 0;
    string test_name = "reset";

    mmu_top DUT (.*);

    always #10 clk = ~clk;                              // 20 ns period

    // --------------------
    // Reference model
    // --------------------

    function automatic logic [`MMU_VADDR_BITS-1:0] expected_physad(
        input logic [`MMU_VADDR_BITS-1:0] vaddr, input logic besm6, input logic no_paging,
        input logic [`MMU_PAGE_BITS-1:0] map [`MMU_NUM_PAGES]);
        logic [`MMU_PAGE_BITS-1:0] vp;
        vp = besm6 ? {5'b0, vaddr[14:10]} : vaddr[19:10];  // Short page in emulation
        if (no_paging) return {vp, vaddr[9:0]};
        return {map[vp], vaddr[9:0]};
    endfunction

    function automatic logic write_class(input arb_op_t op);
        return (op == CCWR) || (op == DCWR) || (op == DWR) || (op == RDMWR) || (op == BTRWR);
    endfunction

    // --------------------
    // Checking
    // --------------------

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAIL %s %s: expected %0h actual %0h", test_name, what, exp, act);
            errors++;
        end
    endtask

    // Physical address is compared whenever ack is high
    always @(negedge clk) begin
        if (o_ack) begin
            checks++;
            assert (o_physad === exp_physad) else begin
                $display("FAIL %s physad: expected %0h actual %0h", test_name, exp_physad,
                         o_physad);
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: run exceeded %0d cycles in test %s", LIMIT, test_name);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // --------------------
    // Stimulus tasks
    // --------------------

    task automatic set_mode(input logic no_paging, input logic besm6);
        @(posedge clk);
        #1;
        i_no_paging = no_paging;
        i_besm6 = besm6;
    endtask

    task automatic stat_write(input logic [9:0] page, input logic u, input logic d,
                              input logic r);
        @(posedge clk);
        #1;
        i_stat_we = 1'b1;
        i_stat_page = page;
        {i_stat_used, i_stat_dirty, i_stat_reprio} = {u, d, r};
        used_sh[page] = u;
        dirty_sh[page] = d;
        reprio_sh[page] = r;
        @(posedge clk);
        #1;
        i_stat_we = 1'b0;
    endtask

    task automatic check_status(input logic [9:0] page);
        @(posedge clk);
        #1;
        i_stat_page = page;
        @(negedge clk);
        check_val("used", {31'b0, used_sh[page]}, {31'b0, o_used});
        check_val("dirty", {31'b0, dirty_sh[page]}, {31'b0, o_dirty});
        check_val("reprio", {31'b0, reprio_sh[page]}, {31'b0, o_reprio});
    endtask

    task automatic map_write(input logic [9:0] vp, input logic [9:0] pp);
        @(posedge clk);
        #1;
        {i_map_we, i_map_vpage, i_map_ppage} = {1'b1, vp, pp};
        map_sh[vp] = pp;
        @(posedge clk);
        #1;
        i_map_we = 1'b0;
    endtask

    task automatic request(input arb_op_t op, input logic [19:0] va, input int extra,
                           input logic preset);
        logic [9:0] pp;
        int lat;
        exp_physad = expected_physad(va, i_besm6, i_no_paging, map_sh);
        pp = exp_physad[19:10];
        if (preset) stat_write(pp, 1'b0, 1'b0, 1'b0);   // Known status before touch
        @(posedge clk);
        #1;
        i_req = 1'b1;
        i_opc = op;
        i_vaddr = va;
        requests++;
        lat = 0;
        while (!o_ack && lat < 20) begin
            @(negedge clk);
            lat++;
        end
        if (!o_ack) begin
            $display("Request in test %s got no ack within 20 cycles", test_name);
            errors++;
        end else begin
            check_val("ack latency", ACK_DELAY, lat);
        end
        used_sh[pp] = 1'b1;                             // Touched once in lookup
        if (write_class(op)) dirty_sh[pp] = 1'b1;
        repeat (extra) begin                            // Back-pressure
            @(negedge clk);
            check_val("ack hold", 1, {31'b0, o_ack});
        end
        if (extra > 0) stat_write(pp, 1'b0, 1'b0, reprio_sh[pp]);  // Second touch shows
        @(posedge clk);
        #1;
        i_req = 1'b0;
        repeat (2) @(negedge clk);                      // Ack drops on the next edge
        check_val("ack release", 0, {31'b0, o_ack});
        check_status(pp);
    endtask

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        int busy, p;
        {reset, i_map_we, i_no_paging, i_besm6, i_req, i_stat_we, i_fill_start} = 7'b1000000;
        {i_map_vpage, i_map_ppage, i_stat_page, i_vaddr} = '0;
        {i_stat_used, i_stat_dirty, i_stat_reprio} = 3'b0;
        i_opc = CCRD;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        test_name = "bypass";                           // Behavior 1
        i_no_paging = 1'b1;
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            request(arb_op_t'(rnd[23:20]), rnd[19:0], 0, 1'b1);
        end

        test_name = "mapped";                           // Behavior 2
        set_mode(1'b0, 1'b0);
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            map_write(rnd[19:10], rnd[29:20]);
            request(arb_op_t'(rnd[3:0]), rnd[19:0], 0, 1'b1);
        end

        test_name = "besm6";                            // Behavior 3
        set_mode(1'b0, 1'b1);
        for (int i = 0; i < 32; i++) begin
            rnd = $random(seed);
            map_write(i[9:0], rnd[9:0]);
        end
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            set_mode(rnd[31], 1'b1);
            request(arb_op_t'(rnd[3:0]), rnd[19:0], 0, 1'b1);
            request(DWR, {~rnd[19:15], rnd[14:0]}, 0, 1'b1);   // Same page expected
        end

        test_name = "soft status";                      // Behavior 4
        set_mode(1'b1, 1'b0);
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            stat_write(rnd[9:0], rnd[10], rnd[11], rnd[12]);
            check_status(rnd[9:0]);
            request(DCRD, {rnd[9:0], rnd[29:20]}, 0, 1'b0);   // Dirty stays
        end

        test_name = "fill";                             // Behavior 5
        @(posedge clk);
        #1;
        {i_stat_we, i_stat_used, i_stat_dirty, i_stat_reprio} = 4'b1000;
        for (p = 0; p < `MMU_NUM_PAGES; p++) begin
            i_stat_page = p[9:0];
            {used_sh[p], dirty_sh[p], reprio_sh[p]} = 3'b0;
            @(posedge clk);
            #1;
        end
        i_stat_we = 1'b0;
        i_fill_start = 1'b1;
        busy = 0;
        p = 0;
        while (p < 1100) begin                          // Count busy cycles
            @(posedge clk);
            #1;
            i_fill_start = (busy == 10);                // Start again while busy
            @(negedge clk);
            if (o_fill_busy) busy++;
            else if (busy > 0) break;
            p++;
        end
        check_val("busy cycles", `MMU_NUM_PAGES, busy);
        for (p = 0; p < `MMU_NUM_PAGES; p++) begin
            reprio_sh[p] = 1'b1;
            check_status(p[9:0]);
        end

        test_name = "backpressure";                     // Behavior 6
        set_mode(1'b0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            map_write(rnd[19:10], rnd[29:20]);
            request(arb_op_t'(rnd[3:0]), rnd[19:0], int'(rnd[31:29]) % 6, 1'b1);
        end

        $display("Checks %0d, errors %0d, requests %0d", checks, errors, requests);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/access_ctrl.sv
// Request handshake FSM, opcode write classification and physical address register
`timescale 1ns/1ps
`default_nettype none

`include "mmu_macros.svh"

module access_ctrl (
    input  logic                        clk,            // System clock
    input  logic                        reset,          // Sync reset, active high
    input  logic                        i_req,          // Four-phase request
    input  mmu_pkg::arb_op_t            i_opc,          // Arbiter operation
    input  logic [`MMU_VADDR_BITS-1:0]  i_vaddr,        // Virtual address
    input  logic [`MMU_PAGE_BITS-1:0]   i_ppage,        // Page from page_map
    output logic                        o_ack,          // Request done
    output logic [`MMU_VADDR_BITS-1:0]  o_physad,       // Physical address
    output logic                        o_touch,        // Status update strobe
    output logic [`MMU_PAGE_BITS-1:0]   o_touch_page,   // Physical page register
    output logic                        o_touch_dirty   // Mark page modified
);

    import mmu_pkg::*;

    acc_state_t                 acc_state;      // Handshake state
    logic                       ack_q;          // Registered acknowledge
    logic                       is_write;       // Opcode is write-class
    logic [`MMU_VADDR_BITS-1:0] physad_q;       // Translated address
    logic [`MMU_PAGE_BITS-1:0]  page_q;         // Page being touched
    logic                       dirty_q;        // Dirty flag for that page

    // --------------------
    // Opcode class
    // --------------------

    always_comb begin
        case (i_opc)
            CCWR, DCWR, DWR, RDMWR, BTRWR: is_write = 1'b1;
            default:                      is_write = 1'b0;   // Reads and unknown codes
        endcase
    end

    // --------------------
    // Handshake FSM
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_state <= ACC_IDLE;
            ack_q     <= 1'b0;
        end else begin
            case (acc_state)
                ACC_IDLE: begin
                    if (i_req) begin
                        acc_state <= ACC_LOOKUP;    // Address already stable
                    end
                end
                ACC_LOOKUP: begin
                    acc_state <= ACC_ACK;
                    ack_q     <= 1'b1;              // Physical address valid now
                end
                ACC_ACK: begin
                    if (!i_req) begin
                        acc_state <= ACC_IDLE;      // Master released request
                        ack_q     <= 1'b0;
                    end
                end
                default: begin
                    acc_state <= ACC_IDLE;
                    ack_q     <= 1'b0;
                end
            endcase
        end
    end

    // --------------------
    // Address and page registers
    // --------------------

    always_ff @(posedge clk) begin
        if (acc_state == ACC_IDLE && i_req) begin
            page_q  <= i_ppage;                     // Held through lookup
            dirty_q <= is_write;
        end
        if (acc_state == ACC_LOOKUP) begin
            physad_q <= {i_ppage, i_vaddr[`MMU_OFFSET_BITS-1:0]};  // Page joined with offset
        end
    end

    assign o_ack         = ack_q;
    assign o_physad      = physad_q;
    assign o_touch       = (acc_state == ACC_LOOKUP);   // Once per request
    assign o_touch_page  = page_q;
    assign o_touch_dirty = dirty_q;

endmodule

`default_nettype wire

// File: verilog/mmu_macros.svh
// Width and size macros for the page translation and page status unit
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// --------------------
// Address split
// --------------------

`define MMU_PAGE_BITS       10      // Virtual and physical page number
`define MMU_OFFSET_BITS     10      // Word offset inside a page
`define MMU_VADDR_BITS      20      // Full virtual or physical address

// BESM-6 emulation sees a 15-bit address space
`define MMU_BESM6_PAGE_BITS 5       // Virtual page in emulation mode

// --------------------
// Memory sizes
// --------------------

`define MMU_NUM_PAGES       1024    // Entries in map and status arrays

// Arbiter request code
`define MMU_OPC_BITS        4       // Arbiter opcode field

`endif

// File: verilog/mmu_pkg.sv
// Package with the arbiter opcode enum and the handshake and fill state enums
`default_nettype none

`include "mmu_macros.svh"

package mmu_pkg;

    // Arbiter operation codes, reads and writes interleaved
    typedef enum logic [`MMU_OPC_BITS-1:0] {
        CCRD  = 4'd1,               // Instruction cache read
        CCWR  = 4'd2,               // Instruction cache write
        DCRD  = 4'd3,               // Operand cache read
        DCWR  = 4'd4,               // Operand cache write
        DRD   = 4'd9,               // Direct read
        DWR   = 4'd10,              // Result write
        RDMWR = 4'd11,              // Read-modify-write
        BTRWR = 4'd12               // Block transfer write
    } arb_op_t;

    // Request handshake controller
    typedef enum logic [1:0] {
        ACC_IDLE   = 2'd0,          // Waiting for i_req
        ACC_LOOKUP = 2'd1,          // Translation settles, touch page
        ACC_ACK    = 2'd2           // Ack high until i_req drops
    } acc_state_t;

    // Reprioritize fill sequencer
    typedef enum logic {
        FILL_IDLE = 1'b0,
        FILL_RUN  = 1'b1            // One page per cycle
    } fill_state_t;

endpackage

`default_nettype wire

// File: verilog/mmu_top.sv
// Top level of the paging unit joining page map, page status and access control
`timescale 1ns/1ps
`default_nettype none

`include "mmu_macros.svh"

module mmu_top (
    input  logic                        clk,            // System clock
    input  logic                        reset,          // Sync reset, active high
    input  logic                        i_map_we,       // Map write port
    input  logic [`MMU_PAGE_BITS-1:0]   i_map_vpage,
    input  logic [`MMU_PAGE_BITS-1:0]   i_map_ppage,
    input  logic                        i_no_paging,    // Mode levels
    input  logic                        i_besm6,
    input  logic                        i_req,          // Request port
    input  mmu_pkg::arb_op_t            i_opc,
    input  logic [`MMU_VADDR_BITS-1:0]  i_vaddr,
    output logic                        o_ack,
    output logic [`MMU_VADDR_BITS-1:0]  o_physad,
    input  logic [`MMU_PAGE_BITS-1:0]   i_stat_page,    // Status port
    input  logic                        i_stat_we,
    input  logic                        i_stat_used,
    input  logic                        i_stat_dirty,
    input  logic                        i_stat_reprio,
    output logic                        o_used,
    output logic                        o_dirty,
    output logic                        o_reprio,
    input  logic                        i_fill_start,   // Fill port
    output logic                        o_fill_busy
);

    logic [`MMU_PAGE_BITS-1:0] ppage;           // Translated page
    logic                      touch;           // Access strobe
    logic [`MMU_PAGE_BITS-1:0] touch_page;      // Page accessed
    logic                      touch_dirty;     // Access was a write

    // --------------------
    // Translation
    // --------------------

    page_map u_page_map (
        .clk         (clk),
        .i_map_we    (i_map_we),
        .i_map_vpage (i_map_vpage),
        .i_map_ppage (i_map_ppage),
        .i_vaddr     (i_vaddr),                 // Same address access_ctrl holds
        .i_besm6     (i_besm6),
        .i_no_paging (i_no_paging),
        .o_ppage     (ppage)
    );

    access_ctrl u_access_ctrl (
        .clk           (clk),
        .reset         (reset),
        .i_req         (i_req),
        .i_opc         (i_opc),
        .i_vaddr       (i_vaddr),
        .i_ppage       (ppage),
        .o_ack         (o_ack),
        .o_physad      (o_physad),
        .o_touch       (touch),
        .o_touch_page  (touch_page),
        .o_touch_dirty (touch_dirty)
    );

    // --------------------
    // Page status
    // --------------------

    page_status u_page_status (
        .clk           (clk),
        .reset         (reset),
        .i_touch       (touch),
        .i_touch_page  (touch_page),
        .i_touch_dirty (touch_dirty),
        .i_stat_page   (i_stat_page),
        .i_stat_we     (i_stat_we),
        .i_stat_used   (i_stat_used),
        .i_stat_dirty  (i_stat_dirty),
        .i_stat_reprio (i_stat_reprio),
        .o_used        (o_used),
        .o_dirty       (o_dirty),
        .o_reprio      (o_reprio),
        .i_fill_start  (i_fill_start),
        .o_fill_busy   (o_fill_busy)
    );

endmodule

`default_nettype wire

// File: verilog/page_map.sv
// Page map memory with its write port and combinational address translation
`timescale 1ns/1ps
`default_nettype none

`include "mmu_macros.svh"

module page_map (
    input  logic                        clk,            // System clock
    input  logic                        i_map_we,       // Map write strobe
    input  logic [`MMU_PAGE_BITS-1:0]   i_map_vpage,    // Virtual page to write
    input  logic [`MMU_PAGE_BITS-1:0]   i_map_ppage,    // Physical page to store
    input  logic [`MMU_VADDR_BITS-1:0]  i_vaddr,        // Address being translated
    input  logic                        i_besm6,        // Emulation mode
    input  logic                        i_no_paging,    // Translation bypass
    output logic [`MMU_PAGE_BITS-1:0]   o_ppage         // Translated page
);

    // --------------------
    // Map storage
    // --------------------

    logic [`MMU_PAGE_BITS-1:0] map_mem [`MMU_NUM_PAGES];  // One physical page per virtual page

    logic [`MMU_PAGE_BITS-1:0]       vpage;              // Virtual page index
    logic [`MMU_BESM6_PAGE_BITS-1:0] vpage_besm6;        // Short page of emulation mode
    logic [`MMU_PAGE_BITS-1:0]       map_rd;             // Raw map read

    // Written at the edge, readable next cycle
    always_ff @(posedge clk) begin
        if (i_map_we) begin
            map_mem[i_map_vpage] <= i_map_ppage;     // Load new mapping
        end
    end

    // --------------------
    // Virtual page select
    // --------------------

    // Emulation mode only decodes bits 14..10
    assign vpage_besm6 =
        i_vaddr[`MMU_OFFSET_BITS +: `MMU_BESM6_PAGE_BITS];

    always_comb begin
        if (i_besm6) begin
            vpage = {{(`MMU_PAGE_BITS - `MMU_BESM6_PAGE_BITS){1'b0}},
                     vpage_besm6};                  // Zero-extended short page
        end else begin
            vpage = i_vaddr[`MMU_VADDR_BITS-1:`MMU_OFFSET_BITS];  // Full page field
        end
    end

    // --------------------
    // Translation
    // --------------------

    assign map_rd = map_mem[vpage];                 // Asynchronous lookup

    always_comb begin
        if (i_no_paging) begin
            o_ppage = vpage;                        // Identity mapping
        end else begin
            o_ppage = map_rd;                       // Mapped page
        end
    end

endmodule

`default_nettype wire

// File: verilog/page_status.sv
// Used, dirty and reprioritize bit arrays with software access and the fill sequencer
`timescale 1ns/1ps
`default_nettype none

`include "mmu_macros.svh"

module page_status (
    input  logic                        clk,            // System clock
    input  logic                        reset,          // Sync reset, active high
    input  logic                        i_touch,        // One-cycle access mark
    input  logic [`MMU_PAGE_BITS-1:0]   i_touch_page,   // Physical page accessed
    input  logic                        i_touch_dirty,  // Access was write-class
    input  logic [`MMU_PAGE_BITS-1:0]   i_stat_page,    // Software page select
    input  logic                        i_stat_we,      // Software write strobe
    input  logic                        i_stat_used,    // Used bit to write
    input  logic                        i_stat_dirty,   // Dirty bit to write
    input  logic                        i_stat_reprio,  // Reprioritize bit to write
    output logic                        o_used,         // Used bit of i_stat_page
    output logic                        o_dirty,        // Dirty bit of i_stat_page
    output logic                        o_reprio,       // Reprio bit of i_stat_page
    input  logic                        i_fill_start,   // Start fill pulse
    output logic                        o_fill_busy     // Fill in progress
);

    import mmu_pkg::*;

    // --------------------
    // Status arrays
    // --------------------

    logic used_mem   [`MMU_NUM_PAGES];      // Page has been referenced
    logic dirty_mem  [`MMU_NUM_PAGES];      // Page has been modified
    logic reprio_mem [`MMU_NUM_PAGES];      // Reprioritize request

    fill_state_t                fill_state;     // Sequencer state
    logic [`MMU_PAGE_BITS-1:0]  fill_cnt;       // Page being filled
    logic                       touch_hit;      // Touch collides with software write
    logic                       fill_run;       // Fill active this cycle

    assign touch_hit = i_touch && (i_touch_page == i_stat_page);
    assign fill_run  = (fill_state == FILL_RUN);

    // --------------------
    // Fill sequencer
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            fill_state <= FILL_IDLE;
            fill_cnt   <= '0;
        end else begin
            case (fill_state)
                FILL_IDLE: begin
                    if (i_fill_start) begin
                        fill_state <= FILL_RUN;     // Begin at page 0
                        fill_cnt   <= '0;
                    end
                end
                FILL_RUN: begin
                    fill_cnt <= fill_cnt + 1'b1;    // Next page
                    if (&fill_cnt) begin
                        fill_state <= FILL_IDLE;    // Last page written
                    end
                end
                default: fill_state <= FILL_IDLE;
            endcase
        end
    end

    assign o_fill_busy = fill_run;                  // Exactly NUM_PAGES cycles

    // --------------------
    // Array updates
    // --------------------

    // Later assignments win, so touches and fill override software
    always_ff @(posedge clk) begin
        if (i_stat_we && !touch_hit) begin
            used_mem[i_stat_page]  <= i_stat_used;
            dirty_mem[i_stat_page] <= i_stat_dirty;
        end
        if (i_stat_we && !fill_run) begin
            reprio_mem[i_stat_page] <= i_stat_reprio;   // Locked out during fill
        end
        if (i_touch) begin
            used_mem[i_touch_page] <= 1'b1;         // Any access marks used
            if (i_touch_dirty) begin
                dirty_mem[i_touch_page] <= 1'b1;    // Write-class marks dirty
            end
        end
        if (fill_run) begin
            reprio_mem[fill_cnt] <= 1'b1;           // Fill with ones
        end
    end

    // Software read port
    assign o_used   = used_mem[i_stat_page];
    assign o_dirty  = dirty_mem[i_stat_page];
    assign o_reprio = reprio_mem[i_stat_page];

endmodule

`default_nettype wire
